/* project.f */
verilog/icache_cfg_pkg.sv
verilog/icache_bus_pkg.sv
verilog/icache_arrays.sv
verilog/refill_engine.sv
verilog/icache_ctrl.sv
verilog/icache_top.sv
tests/tb_clock_gen.sv
tests/tb_mem_model.sv
tests/icache_assertions.sv
tests/tb_icache_top.sv

/* Makefile */
# Verilator lint, simulation and clean targets for the instruction cache

VERILATOR  ?= verilator
TOP        ?= tb_icache_top
FILELIST   ?= project.f
OBJ_DIR    ?= obj_dir
LINT_FLAGS ?= --lint-only -Wall --timing --assert
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal
PASS_TEXT  ?= TB PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# The run passes only if the testbench printed the pass line
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

/* tests/tb_icache_top.sv */
`timescale 1ns/10ps
// Instruction cache testbench driven from a table of fetches
// Checks data, error flags and memory requests against the memory rule
module tb_icache_top
    import icache_cfg_pkg::*;
    import icache_bus_pkg::*;
();

    localparam int TIMEOUT = 200;

    typedef struct packed {
        logic [ADDR_W-1:0]   addr;
        logic                cacheable;
        logic                flush_before;
        logic                new_req;
        logic [FETCH_DW-1:0] exp_data;
        logic                exp_error;
    } fetch_entry_t;

    logic                clk;
    logic                reset;
    logic [ADDR_W-1:0]   inst_addr;
    logic                inst_cacheable;
    logic                inst_valid;
    logic                inst_ready;
    logic [FETCH_DW-1:0] inst_data;
    logic                inst_error;
    logic                flush_valid;
    logic                flush_ready;
    mem_req_t            refill_q;
    logic                refill_qvalid;
    logic                refill_qready;
    mem_rsp_t            refill_p;
    logic                refill_pvalid;
    logic                refill_pready;

    fetch_entry_t entries[$];
    integer       checks;
    integer       errors;
    logic         timed_out;

    tb_clock_gen u_tb_clock_gen (
        .clk_o   ( clk   ),
        .reset_o ( reset )
    );

    icache_top u_icache_top (
        .clk_i            ( clk            ),
        .reset_i          ( reset          ),
        .inst_addr_i      ( inst_addr      ),
        .inst_cacheable_i ( inst_cacheable ),
        .inst_valid_i     ( inst_valid     ),
        .inst_ready_o     ( inst_ready     ),
        .inst_data_o      ( inst_data      ),
        .inst_error_o     ( inst_error     ),
        .flush_valid_i    ( flush_valid    ),
        .flush_ready_o    ( flush_ready    ),
        .refill_q_o       ( refill_q       ),
        .refill_qvalid_o  ( refill_qvalid  ),
        .refill_qready_i  ( refill_qready  ),
        .refill_p_i       ( refill_p       ),
        .refill_pvalid_i  ( refill_pvalid  ),
        .refill_pready_o  ( refill_pready  )
    );

    tb_mem_model u_mem_model (
        .clk_i    ( clk           ),
        .reset_i  ( reset         ),
        .req_i    ( refill_q      ),
        .qvalid_i ( refill_qvalid ),
        .qready_o ( refill_qready ),
        .rsp_o    ( refill_p      ),
        .pvalid_o ( refill_pvalid ),
        .pready_i ( refill_pready )
    );

    function automatic logic [FETCH_DW-1:0] rule_word(input logic [ADDR_W-1:0] addr);
        return {addr[ADDR_W-1:2], 2'b00} ^ 32'hA5A5_0000;
    endfunction

    task automatic add_entry(input logic [ADDR_W-1:0] addr, input logic cacheable,
                             input logic flush_before, input logic new_req);
        fetch_entry_t e;
        e.addr         = addr;
        e.cacheable    = cacheable;
        e.flush_before = flush_before;
        e.new_req      = new_req;
        e.exp_data     = rule_word(addr);
        e.exp_error    = (addr >= 32'hF000_0000);
        entries.push_back(e);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks = checks + 1;
        if (got !== exp) begin
            errors = errors + 1;
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic build_entries();
        // Miss then hits on every word of one line
        add_entry(32'h0000_1008, 1'b1, 1'b0, 1'b1);
        add_entry(32'h0000_1000, 1'b1, 1'b0, 1'b0);
        add_entry(32'h0000_1004, 1'b1, 1'b0, 1'b0);
        add_entry(32'h0000_100C, 1'b1, 1'b0, 1'b0);
        // Alternating tags on one index
        add_entry(32'h0000_2004, 1'b1, 1'b0, 1'b1);
        add_entry(32'h0000_1004, 1'b1, 1'b0, 1'b1);
        add_entry(32'h0000_2008, 1'b1, 1'b0, 1'b1);
        add_entry(32'h0000_200C, 1'b1, 1'b0, 1'b0);
        // Bypass reads on a cached line and with a byte offset
        add_entry(32'h0000_2008, 1'b0, 1'b0, 1'b1);
        add_entry(32'h0000_3016, 1'b0, 1'b0, 1'b1);
        add_entry(32'h0000_2000, 1'b1, 1'b0, 1'b0);
        // Error region
        add_entry(32'hF000_0040, 1'b1, 1'b0, 1'b1);
        add_entry(32'hF000_0044, 1'b1, 1'b0, 1'b0);
        add_entry(32'hF000_0010, 1'b0, 1'b0, 1'b1);
        // Flush drops every cached line
        add_entry(32'h0000_200C, 1'b1, 1'b1, 1'b1);
        add_entry(32'h0000_2000, 1'b1, 1'b0, 1'b0);
        add_entry(32'hF000_004C, 1'b1, 1'b0, 1'b1);
    endtask

    task automatic run_flush();
        integer tries;
        flush_valid = 1'b1;
        tries       = 0;
        @(negedge clk);
        while (!flush_ready && tries < TIMEOUT) begin
            @(negedge clk);
            tries = tries + 1;
        end
        if (!flush_ready) begin
            timed_out = 1'b1;
            $display("Timeout at %0t: flush_ready_o never pulsed after a flush request", $time);
        end else begin
            @(posedge clk);
            #1;
            flush_valid = 1'b0;
        end
    endtask

    task automatic run_fetch(input fetch_entry_t e);
        integer              tries;
        integer              count_before;
        logic [FETCH_DW-1:0] got_data;
        logic                got_error;
        logic [ADDR_W-1:0]   exp_addr;
        count_before   = u_mem_model.req_count;
        exp_addr       = e.cacheable ? (e.addr & ~32'hF) : (e.addr & ~32'h3);
        inst_addr      = e.addr;
        inst_cacheable = e.cacheable;
        inst_valid     = 1'b1;
        tries          = 0;
        @(negedge clk);
        while (!inst_ready && tries < TIMEOUT) begin
            @(negedge clk);
            tries = tries + 1;
        end
        if (!inst_ready) begin
            timed_out = 1'b1;
            $display("Timeout at %0t: no inst_ready_o for the fetch at %h", $time, e.addr);
        end else begin
            got_data  = inst_data;
            got_error = inst_error;
            // Hold valid through the cycle in which ready is high
            @(posedge clk);
            #1;
            inst_valid = 1'b0;
            check_value("inst_data_o", got_data, e.exp_data);
            check_value("inst_error_o", 32'(got_error), 32'(e.exp_error));
            check_value("refill request count", u_mem_model.req_count - count_before,
                        32'(e.new_req));
            if (e.new_req) begin
                check_value("refill_q_o.addr", u_mem_model.last_addr, exp_addr);
                check_value("refill_q_o.len", 32'(u_mem_model.last_len),
                            e.cacheable ? 32'(LINE_LEN) : 32'd0);
            end
            // The idle controller takes the fetch at the first edge after it is driven
            if (e.cacheable && !e.new_req) begin
                check_value("inst_ready_o hit latency", 32'(tries - 1), 32'd2);
            end
        end
    endtask

    initial begin
        integer tries;
        inst_addr      = '0;
        inst_cacheable = 1'b0;
        inst_valid     = 1'b0;
        flush_valid    = 1'b0;
        checks         = 0;
        errors         = 0;
        timed_out      = 1'b0;
        build_entries();
        tries = 0;
        @(posedge clk);
        while (reset && tries < TIMEOUT) begin
            @(posedge clk);
            tries = tries + 1;
        end
        if (reset) begin
            timed_out = 1'b1;
            $display("Timeout at %0t: reset_i never went low", $time);
        end
        @(posedge clk);
        #1;
        foreach (entries[i]) begin
            if (!timed_out && entries[i].flush_before) begin
                run_flush();
            end
            if (!timed_out) begin
                run_fetch(entries[i]);
            end
        end
        $display("Checks: %0d, errors: %0d, timeouts: %0d, memory model errors: %0d",
                 checks, errors, timed_out, u_mem_model.fail_count);
        if (errors == 0 && !timed_out && u_mem_model.fail_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

/* tests/icache_assertions.sv */
`timescale 1ns/10ps
// Concurrent checks on the memory request channel and the fetch handshake
module icache_assertions
    import icache_cfg_pkg::*;
    import icache_bus_pkg::*;
(
    input logic     clk_i,
    input logic     reset_i,
    input logic     inst_valid_i,
    input logic     inst_ready_o,
    input mem_req_t refill_q_o,
    input logic     refill_qvalid_o,
    input logic     refill_qready_i
);

    // Request held while memory stalls it
    req_stable_a: assert property (@(posedge clk_i) disable iff (reset_i)
        refill_qvalid_o && !refill_qready_i |=> $stable(refill_q_o))
        else $error("refill_q_o changed while waiting for refill_qready_i");

    ready_needs_valid_a: assert property (@(posedge clk_i) disable iff (reset_i)
        inst_ready_o |-> inst_valid_i)
        else $error("inst_ready_o high without inst_valid_i");

    req_len_a: assert property (@(posedge clk_i) disable iff (reset_i)
        refill_qvalid_o |-> (refill_q_o.len == 8'd0 || refill_q_o.len == 8'(LINE_LEN)))
        else $error("refill request with an unexpected length");

    qvalid_after_reset_a: assert property (@(posedge clk_i)
        reset_i |=> !refill_qvalid_o)
        else $error("refill_qvalid_o high in the cycle after reset");

endmodule

bind icache_top icache_assertions u_icache_assertions (
    .clk_i           ( clk_i           ),
    .reset_i         ( reset_i         ),
    .inst_valid_i    ( inst_valid_i    ),
    .inst_ready_o    ( inst_ready_o    ),
    .refill_q_o      ( refill_q_o      ),
    .refill_qvalid_o ( refill_qvalid_o ),
    .refill_qready_i ( refill_qready_i )
);

/* tests/tb_mem_model.sv */
`timescale 1ns/10ps
// Behavioral burst read memory for the cache testbench
// Word at aligned address A reads A XOR A5A50000, top region returns errors
module tb_mem_model
    import icache_cfg_pkg::*;
    import icache_bus_pkg::*;
(
    input  logic     clk_i,
    input  logic     reset_i,
    input  mem_req_t req_i,
    input  logic     qvalid_i,
    output logic     qready_o,
    output mem_rsp_t rsp_o,
    output logic     pvalid_o,
    input  logic     pready_i
);

    integer            seed;
    integer            req_count;
    integer            fail_count;
    logic [7:0]        last_len;
    logic [ADDR_W-1:0] last_addr;

    initial begin
        integer            gap;
        integer            tries;
        mem_req_t          req;
        logic [ADDR_W-1:0] beat_addr;
        seed       = 32'h6d61;
        req_count  = 0;
        fail_count = 0;
        last_len   = '0;
        last_addr  = '0;
        qready_o   = 1'b0;
        pvalid_o   = 1'b0;
        rsp_o      = '0;
        forever begin
            @(negedge clk_i);
            if (!reset_i && qvalid_i) begin
                // Accept after 0 to 3 cycles
                gap = {$random(seed)} % 4;
                repeat (gap) @(posedge clk_i);
                @(posedge clk_i);
                #1;
                qready_o = 1'b1;
                req      = req_i;
                @(posedge clk_i);
                #1;
                qready_o  = 1'b0;
                req_count = req_count + 1;
                last_len  = req.len;
                last_addr = req.addr;
                for (int i = 0; i <= int'(req.len); i++) begin
                    // Up to 2 idle cycles before each beat
                    gap = {$random(seed)} % 3;
                    repeat (gap) begin
                        @(posedge clk_i);
                        #1;
                    end
                    beat_addr   = req.addr + ADDR_W'(4 * i);
                    rsp_o.data  = {beat_addr[ADDR_W-1:2], 2'b00} ^ 32'hA5A5_0000;
                    rsp_o.error = (beat_addr >= 32'hF000_0000);
                    rsp_o.last  = (i == int'(req.len));
                    pvalid_o    = 1'b1;
                    tries       = 0;
                    @(negedge clk_i);
                    while (!pready_i && tries < 200) begin
                        @(negedge clk_i);
                        tries = tries + 1;
                    end
                    if (!pready_i) begin
                        fail_count = fail_count + 1;
                        $display("Memory model at %0t: refill_pready_o never rose for a beat",
                                 $time);
                    end
                    @(posedge clk_i);
                    #1;
                    pvalid_o = 1'b0;
                end
            end
        end
    end

endmodule

/* tests/tb_clock_gen.sv */
`timescale 1ns/10ps
// Testbench clock with a 100 ns period and a 5-cycle reset
module tb_clock_gen (
    output logic clk_o,
    output logic reset_o
);

    initial begin
        clk_o = 1'b0;
        forever #50 clk_o = ~clk_o;
    end

    initial begin
        reset_o = 1'b1;
        repeat (5) @(posedge clk_o);
        #1;
        reset_o = 1'b0;
    end

endmodule

/* verilog/icache_top.sv */
`timescale 1ns/10ps
// Instruction cache top level
// Connects the fetch controller, the line arrays and the refill engine
module icache_top
    import icache_cfg_pkg::*;
    import icache_bus_pkg::*;
(
    input  logic                clk_i,
    input  logic                reset_i,

    input  logic [ADDR_W-1:0]   inst_addr_i,
    input  logic                inst_cacheable_i,
    input  logic                inst_valid_i,
    output logic                inst_ready_o,
    output logic [FETCH_DW-1:0] inst_data_o,
    output logic                inst_error_o,

    input  logic                flush_valid_i,
    output logic                flush_ready_o,

    // AXI-like burst read port
    output mem_req_t            refill_q_o,
    output logic                refill_qvalid_o,
    input  logic                refill_qready_i,
    input  mem_rsp_t            refill_p_i,
    input  logic                refill_pvalid_i,
    output logic                refill_pready_o
);

    logic [INDEX_W-1:0]    rd_index;
    logic [TAG_W-1:0]      rd_tag;
    logic                  rd_valid;
    logic                  rd_error;
    logic [LINE_WIDTH-1:0] rd_data;
    line_wr_t              wr;
    logic                  wr_en;
    logic                  flush_start;
    logic                  flush_done;

    refill_req_t refill_req;
    logic        req_valid;
    logic        req_ready;
    line_rsp_t   line_rsp;
    logic        rsp_valid;
    logic        rsp_ready;

    icache_ctrl u_icache_ctrl (
        .clk_i            ( clk_i            ),
        .reset_i          ( reset_i          ),
        .inst_addr_i      ( inst_addr_i      ),
        .inst_cacheable_i ( inst_cacheable_i ),
        .inst_valid_i     ( inst_valid_i     ),
        .inst_ready_o     ( inst_ready_o     ),
        .inst_data_o      ( inst_data_o      ),
        .inst_error_o     ( inst_error_o     ),
        .flush_valid_i    ( flush_valid_i    ),
        .flush_ready_o    ( flush_ready_o    ),
        .rd_index_o       ( rd_index         ),
        .rd_tag_i         ( rd_tag           ),
        .rd_valid_i       ( rd_valid         ),
        .rd_error_i       ( rd_error         ),
        .rd_data_i        ( rd_data          ),
        .wr_o             ( wr               ),
        .wr_en_o          ( wr_en            ),
        .flush_start_o    ( flush_start      ),
        .flush_done_i     ( flush_done       ),
        .refill_req_o     ( refill_req       ),
        .req_valid_o      ( req_valid        ),
        .req_ready_i      ( req_ready        ),
        .line_rsp_i       ( line_rsp         ),
        .rsp_valid_i      ( rsp_valid        ),
        .rsp_ready_o      ( rsp_ready        )
    );

    icache_arrays u_icache_arrays (
        .clk_i         ( clk_i       ),
        .reset_i       ( reset_i     ),
        .rd_index_i    ( rd_index    ),
        .rd_tag_o      ( rd_tag      ),
        .rd_valid_o    ( rd_valid    ),
        .rd_error_o    ( rd_error    ),
        .rd_data_o     ( rd_data     ),
        .wr_i          ( wr          ),
        .wr_en_i       ( wr_en       ),
        .flush_start_i ( flush_start ),
        .flush_done_o  ( flush_done  )
    );

    refill_engine u_refill_engine (
        .clk_i           ( clk_i           ),
        .reset_i         ( reset_i         ),
        .refill_req_i    ( refill_req      ),
        .req_valid_i     ( req_valid       ),
        .req_ready_o     ( req_ready       ),
        .line_rsp_o      ( line_rsp        ),
        .rsp_valid_o     ( rsp_valid       ),
        .rsp_ready_i     ( rsp_ready       ),
        .refill_q_o      ( refill_q_o      ),
        .refill_qvalid_o ( refill_qvalid_o ),
        .refill_qready_i ( refill_qready_i ),
        .refill_p_i      ( refill_p_i      ),
        .refill_pvalid_i ( refill_pvalid_i ),
        .refill_pready_o ( refill_pready_o )
    );

endmodule

/* verilog/icache_ctrl.sv */
`timescale 1ns/10ps
// Fetch controller FSM for hit, miss, bypass and flush
module icache_ctrl
    import icache_cfg_pkg::*;
    import icache_bus_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  reset_i,

    input  logic [ADDR_W-1:0]     inst_addr_i,
    input  logic                  inst_cacheable_i,
    input  logic                  inst_valid_i,
    output logic                  inst_ready_o,
    output logic [FETCH_DW-1:0]   inst_data_o,
    output logic                  inst_error_o,
    input  logic                  flush_valid_i,
    output logic                  flush_ready_o,

    output logic [INDEX_W-1:0]    rd_index_o,
    input  logic [TAG_W-1:0]      rd_tag_i,
    input  logic                  rd_valid_i,
    input  logic                  rd_error_i,
    input  logic [LINE_WIDTH-1:0] rd_data_i,
    output line_wr_t              wr_o,
    output logic                  wr_en_o,
    output logic                  flush_start_o,
    input  logic                  flush_done_i,

    output refill_req_t           refill_req_o,
    output logic                  req_valid_o,
    input  logic                  req_ready_i,
    input  line_rsp_t             line_rsp_i,
    input  logic                  rsp_valid_i,
    output logic                  rsp_ready_o
);

    typedef enum logic [2:0] {
        S_IDLE, S_READ, S_COMPARE, S_REQ, S_WAIT, S_FLUSH, S_DONE
    } state_e;

    state_e                state_q;
    fetch_addr_u           addr_q;
    fetch_addr_u           req_addr;
    logic                  bypass_q;
    logic                  ready_q;
    logic                  flush_ready_q;
    logic [FETCH_DW-1:0]   data_q;
    logic                  error_q;
    logic                  hit;
    logic                  take_fetch;
    logic [WORD_SEL_W-1:0] rsp_sel;

    // Flush wins over a fetch arriving in the same idle cycle
    assign take_fetch = (state_q == S_IDLE) && !flush_valid_i && inst_valid_i;
    assign hit = rd_valid_i && (rd_tag_i == addr_q.fields.tag);
    // Bypass data always sits in the low word of the returned line
    assign rsp_sel = bypass_q ? '0 : addr_q.fields.word_sel;

    assign rd_index_o = addr_q.fields.index;

    // Word address for bypass reads, line address for fills
    always_comb begin
        req_addr = addr_q;
        req_addr.fields.byte_off = '0;
        if (!bypass_q) begin
            req_addr.fields.word_sel = '0;
        end
    end

    assign refill_req_o.addr   = req_addr.raw;
    assign refill_req_o.bypass = bypass_q;
    assign req_valid_o = (state_q == S_REQ);
    assign rsp_ready_o = (state_q == S_WAIT);

    assign wr_en_o     = (state_q == S_WAIT) && rsp_valid_i && !bypass_q;
    assign wr_o.index  = addr_q.fields.index;
    assign wr_o.tag    = addr_q.fields.tag;
    assign wr_o.data   = line_rsp_i.data;
    assign wr_o.error  = line_rsp_i.error;

    assign flush_start_o = (state_q == S_IDLE) && flush_valid_i;

    assign inst_ready_o  = ready_q;
    assign inst_data_o   = data_q;
    assign inst_error_o  = error_q;
    assign flush_ready_o = flush_ready_q;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q       <= S_IDLE;
            ready_q       <= 1'b0;
            flush_ready_q <= 1'b0;
        end else begin
            case (state_q)
                S_IDLE: begin
                    if (flush_valid_i) begin
                        state_q <= S_FLUSH;
                    end else if (inst_valid_i) begin
                        state_q <= inst_cacheable_i ? S_READ : S_REQ;
                    end
                end
                // Arrays register the lookup of the captured index
                S_READ: state_q <= S_COMPARE;
                S_COMPARE: begin
                    if (hit) begin
                        ready_q <= 1'b1;
                        state_q <= S_DONE;
                    end else begin
                        state_q <= S_REQ;
                    end
                end
                S_REQ: begin
                    if (req_ready_i) begin
                        state_q <= S_WAIT;
                    end
                end
                S_WAIT: begin
                    if (rsp_valid_i) begin
                        ready_q <= 1'b1;
                        state_q <= S_DONE;
                    end
                end
                S_FLUSH: begin
                    if (flush_done_i) begin
                        flush_ready_q <= 1'b1;
                        state_q       <= S_DONE;
                    end
                end
                // One cycle of handshake pulse before the next request is looked at
                S_DONE: begin
                    ready_q       <= 1'b0;
                    flush_ready_q <= 1'b0;
                    state_q       <= S_IDLE;
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (take_fetch) begin
            addr_q.raw <= inst_addr_i;
            bypass_q   <= !inst_cacheable_i;
        end
        if (state_q == S_COMPARE) begin
            data_q  <= rd_data_i[addr_q.fields.word_sel * FETCH_DW +: FETCH_DW];
            error_q <= rd_error_i;
        end
        if ((state_q == S_WAIT) && rsp_valid_i) begin
            data_q  <= line_rsp_i.data[rsp_sel * FETCH_DW +: FETCH_DW];
            error_q <= line_rsp_i.error;
        end
    end

endmodule

/* verilog/refill_engine.sv */
`timescale 1ns/10ps
// Refill engine that turns line and bypass requests into memory bursts
// Collects the beats into one line with an OR of their error flags
module refill_engine
    import icache_cfg_pkg::*;
    import icache_bus_pkg::*;
(
    input  logic        clk_i,
    input  logic        reset_i,

    input  refill_req_t refill_req_i,
    input  logic        req_valid_i,
    output logic        req_ready_o,
    output line_rsp_t   line_rsp_o,
    output logic        rsp_valid_o,
    input  logic        rsp_ready_i,

    output mem_req_t    refill_q_o,
    output logic        refill_qvalid_o,
    input  logic        refill_qready_i,
    input  mem_rsp_t    refill_p_i,
    input  logic        refill_pvalid_i,
    output logic        refill_pready_o
);

    typedef enum logic [1:0] {
        S_IDLE, S_ISSUE, S_COLLECT, S_PRESENT
    } state_e;

    state_e                              state_q;
    refill_req_t                         req_q;
    logic [LINE_WIDTH-1:0]               line_q;
    logic                                error_q;
    logic [$clog2(BEATS_PER_LINE)-1:0]   beat_q;
    logic                                req_take;
    logic                                beat_take;

    assign req_ready_o     = (state_q == S_IDLE);
    assign refill_qvalid_o = (state_q == S_ISSUE);
    assign refill_pready_o = (state_q == S_COLLECT);
    assign rsp_valid_o     = (state_q == S_PRESENT);

    assign req_take  = req_valid_i && req_ready_o;
    assign beat_take = refill_pvalid_i && refill_pready_o;

    // A bypass read is a single beat
    assign refill_q_o.addr = req_q.addr;
    assign refill_q_o.len  = req_q.bypass ? 8'd0 : 8'(LINE_LEN);

    assign line_rsp_o.data  = line_q;
    assign line_rsp_o.error = error_q;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q <= S_IDLE;
            beat_q  <= '0;
        end else begin
            case (state_q)
                S_IDLE: begin
                    if (req_take) begin
                        state_q <= S_ISSUE;
                        beat_q  <= '0;
                    end
                end
                S_ISSUE: begin
                    if (refill_qready_i) begin
                        state_q <= S_COLLECT;
                    end
                end
                S_COLLECT: begin
                    if (beat_take) begin
                        beat_q <= beat_q + 1'b1;
                        if (refill_p_i.last) begin
                            state_q <= S_PRESENT;
                        end
                    end
                end
                S_PRESENT: begin
                    if (rsp_ready_i) begin
                        state_q <= S_IDLE;
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    // Beats fill the line from the low word upwards
    always_ff @(posedge clk_i) begin
        if (req_take) begin
            req_q   <= refill_req_i;
            line_q  <= '0;
            error_q <= 1'b0;
        end else if (beat_take) begin
            line_q[beat_q * FILL_DW +: FILL_DW] <= refill_p_i.data;
            error_q <= error_q | refill_p_i.error;
        end
    end

endmodule

/* verilog/icache_arrays.sv */
`timescale 1ns/10ps
// Tag, valid, error and data storage of the direct-mapped cache
// Registered read port, write port and valid-bit flush sweep
module icache_arrays
    import icache_cfg_pkg::*;
    import icache_bus_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  reset_i,
    input  logic [INDEX_W-1:0]    rd_index_i,
    output logic [TAG_W-1:0]      rd_tag_o,
    output logic                  rd_valid_o,
    output logic                  rd_error_o,
    output logic [LINE_WIDTH-1:0] rd_data_o,
    input  line_wr_t              wr_i,
    input  logic                  wr_en_i,
    input  logic                  flush_start_i,
    output logic                  flush_done_o
);

    logic [LINE_WIDTH-1:0] data_mem [LINE_COUNT];
    logic [TAG_W-1:0]      tag_mem  [LINE_COUNT];
    logic                  err_mem  [LINE_COUNT];
    logic [LINE_COUNT-1:0] valid_q;
    logic                  flush_busy_q;
    logic [INDEX_W-1:0]    flush_idx_q;
    logic                  flush_done_q;
    logic                  flush_last;

    assign flush_last   = flush_busy_q && (flush_idx_q == INDEX_W'(LINE_COUNT - 1));
    assign flush_done_o = flush_done_q;

    always_ff @(posedge clk_i) begin
        if (wr_en_i) begin
            data_mem[wr_i.index] <= wr_i.data;
            tag_mem[wr_i.index]  <= wr_i.tag;
            err_mem[wr_i.index]  <= wr_i.error;
        end
        rd_data_o  <= data_mem[rd_index_i];
        rd_tag_o   <= tag_mem[rd_index_i];
        rd_error_o <= err_mem[rd_index_i];
    end

    // Valid bits and the flush walker that clears one index per cycle
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            valid_q      <= '0;
            flush_busy_q <= 1'b0;
            flush_idx_q  <= '0;
            flush_done_q <= 1'b0;
            rd_valid_o   <= 1'b0;
        end else begin
            rd_valid_o   <= valid_q[rd_index_i];
            flush_done_q <= flush_last;
            if (wr_en_i) begin
                valid_q[wr_i.index] <= 1'b1;
            end
            if (flush_start_i) begin
                flush_busy_q <= 1'b1;
                flush_idx_q  <= '0;
            end else if (flush_busy_q) begin
                valid_q[flush_idx_q] <= 1'b0;
                flush_idx_q          <= flush_idx_q + 1'b1;
                if (flush_last) begin
                    flush_busy_q <= 1'b0;
                end
            end
        end
    end

endmodule

/* verilog/icache_bus_pkg.sv */
// Transfer structs between controller, arrays and refill engine
// Request and response channels of the burst read memory
package icache_bus_pkg;

    import icache_cfg_pkg::*;

    // Bypass requests carry a word address, line fills a line address
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic              bypass;
    } refill_req_t;

    typedef struct packed {
        logic [LINE_WIDTH-1:0] data;
        logic                  error;
    } line_rsp_t;

    typedef struct packed {
        logic [INDEX_W-1:0]    index;
        logic [TAG_W-1:0]      tag;
        logic [LINE_WIDTH-1:0] data;
        logic                  error;
    } line_wr_t;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [7:0]        len;
    } mem_req_t;

    typedef struct packed {
        logic [FILL_DW-1:0] data;
        logic               error;
        logic               last;
    } mem_rsp_t;

endpackage

/* verilog/icache_cfg_pkg.sv */
// Cache geometry constants for the direct-mapped instruction cache
// Fetch address union with tag, index, word select and byte offset fields
package icache_cfg_pkg;

    localparam int ADDR_W         = 32;
    localparam int FETCH_DW       = 32;
    localparam int FILL_DW        = 32;
    localparam int LINE_WIDTH     = 128;
    localparam int LINE_COUNT     = 16;

    // Memory beats per line and the burst length field that fetches one line
    localparam int BEATS_PER_LINE = LINE_WIDTH / FILL_DW;
    localparam int LINE_LEN       = BEATS_PER_LINE - 1;

    localparam int INDEX_W        = $clog2(LINE_COUNT);
    localparam int WORD_SEL_W     = $clog2(LINE_WIDTH / FETCH_DW);
    localparam int BYTE_OFF_W     = $clog2(FETCH_DW / 8);
    localparam int TAG_W          = ADDR_W - INDEX_W - WORD_SEL_W - BYTE_OFF_W;

    // Field view of a fetch address with the most significant field first
    typedef struct packed {
        logic [TAG_W-1:0]      tag;
        logic [INDEX_W-1:0]    index;
        logic [WORD_SEL_W-1:0] word_sel;
        logic [BYTE_OFF_W-1:0] byte_off;
    } fetch_fields_t;

    typedef union packed {
        logic [ADDR_W-1:0] raw;
        fetch_fields_t     fields;
    } fetch_addr_u;

endpackage
